// ==== hdl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

   typedef logic [31:0] word_t;

   localparam logic [3:0] pc_reg = 4'd15;   // r15 is the program counter

   typedef enum logic [2:0] {
      cls_alu_r = 3'd0,
      cls_alu_i = 3'd1,
      cls_call  = 3'd2,
      cls_nop   = 3'd3,   // ext slot, does nothing
      cls_st_r  = 3'd4,
      cls_ld_r  = 3'd5,
      cls_st_i  = 3'd6,
      cls_ld_i  = 3'd7
   } inst_class_e;

   typedef enum logic [3:0] {
      op_add, op_sub, op_and, op_or, op_xor,
      op_shl, op_shr, op_mov,
      op_cmp, op_tst   // flags only
   } alu_op_e;

   typedef enum logic [3:0] {
      cond_al, cond_eq, cond_ne, cond_cs, cond_cc,
      cond_mi, cond_pl, cond_vs, cond_vc, cond_nv
   } cond_e;

   typedef struct packed {
      logic c;
      logic s;
      logic z;
      logic v;
   } flags_t;

   // one strobe per cycle, f first after reset
   typedef struct packed {
      logic f;
      logic e;
      logic m;
      logic w;
   } phase_t;

   typedef struct packed {
      inst_class_e cls;
      cond_e       cond;
      logic [3:0]  rd;
      logic [3:0]  ra;
      logic [3:0]  rb;
      alu_op_e     op;
      logic [15:0] imm;
      logic        flag_wb;
      logic        ld;
      logic        st;
      logic        call;
      logic        wb;
   } decode_t;

   typedef struct packed {
      word_t addr;
      word_t wdata;
      logic  wen;
   } mem_req_t;

endpackage

`default_nettype wire

// ==== hdl/phase_sched.sv ====
`timescale 1ns/1ps
`default_nettype none

module phase_sched (
   input  wire              clk,
   input  wire              reset,
   output cpu_pkg::phase_t  phase
);

   // ring f -> e -> m -> w -> f
   always_ff @(posedge clk)
   begin
      if (reset)
         phase <= '{f: 1'b1, default: 1'b0};
      else
         phase <= '{f: phase.w, e: phase.f, m: phase.e, w: phase.m};
   end

   // the ring must never lose or duplicate its token
   a_phase_onehot : assert property (@(posedge clk) disable iff (reset)
      $onehot(phase));

endmodule

`default_nettype wire

// ==== hdl/reg_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_bank (
   input  wire                  clk,
   input  wire                  reset,
   input  wire [3:0]            ra_idx,
   input  wire [3:0]            rb_idx,
   input  wire [3:0]            wr_idx,
   input  wire                  wr_en,
   input  wire cpu_pkg::word_t  wr_data,
   input  wire                  pc_inc,
   output cpu_pkg::word_t       ra_data,
   output cpu_pkg::word_t       rb_data,
   output cpu_pkg::word_t       pc,
   input  wire [3:0]            test_rsel,
   output cpu_pkg::word_t       test_reg
);

   cpu_pkg::word_t regs [16];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < 16; i++)
            regs[i] <= '0;
      end
      else
      begin
         if (wr_en)
            regs[wr_idx] <= wr_data;
         // a jump into r15 wins over the increment
         if (pc_inc && !(wr_en && wr_idx == cpu_pkg::pc_reg))
            regs[cpu_pkg::pc_reg] <= regs[cpu_pkg::pc_reg] + 32'd1;
      end
   end

   assign ra_data  = regs[ra_idx];
   assign rb_data  = regs[rb_idx];
   assign pc       = regs[cpu_pkg::pc_reg];
   assign test_reg = regs[test_rsel];   // readback for the test port

   // increment (phase e) and writeback (phase w) come from different phases
   a_no_pc_clash : assert property (@(posedge clk) disable iff (reset)
      !(wr_en && pc_inc && wr_idx != cpu_pkg::pc_reg));

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
   input  wire cpu_pkg::alu_op_e  op,
   input  wire cpu_pkg::word_t    a,
   input  wire cpu_pkg::word_t    b,
   input  wire cpu_pkg::flags_t   fi,
   output cpu_pkg::word_t         res,
   output cpu_pkg::flags_t        fo,
   output logic                   wb_en,
   output logic                   flag_en
);

   logic           sub_op;
   cpu_pkg::word_t bx;    // b, inverted for subtraction
   logic [32:0]    sum;   // carry out in bit 32

   assign sub_op = (op == cpu_pkg::op_sub) || (op == cpu_pkg::op_cmp);
   assign bx     = sub_op ? ~b : b;
   assign sum    = {1'b0, a} + {1'b0, bx} + {32'd0, sub_op};

   always_comb
   begin
      res     = sum[31:0];
      fo.c    = fi.c;   // c and v pass through unless add/sub
      fo.v    = fi.v;
      wb_en   = 1'b1;
      flag_en = 1'b1;
      case (op)
         cpu_pkg::op_add,
         cpu_pkg::op_sub,
         cpu_pkg::op_cmp:
         begin
            fo.c = sum[32];   // no borrow on sub
            fo.v = (a[31] == bx[31]) && (sum[31] != a[31]);
            if (op == cpu_pkg::op_cmp)
               wb_en = 1'b0;
         end
         cpu_pkg::op_and:
            res = a & b;
         cpu_pkg::op_tst:
         begin
            res   = a & b;
            wb_en = 1'b0;
         end
         cpu_pkg::op_or:
            res = a | b;
         cpu_pkg::op_xor:
            res = a ^ b;
         cpu_pkg::op_shl:
            res = a << b[4:0];
         cpu_pkg::op_shr:
            res = a >> b[4:0];   // logical
         cpu_pkg::op_mov:
            res = b;
         default:
         begin
            // unused op codes do nothing
            res     = '0;
            wb_en   = 1'b0;
            flag_en = 1'b0;
         end
      endcase
      fo.s = res[31];
      fo.z = (res == '0);
   end

endmodule

`default_nettype wire

// ==== hdl/cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
   input  wire                    clk,
   input  wire                    reset,
   input  wire cpu_pkg::phase_t   phase,
   input  wire cpu_pkg::word_t    mem_rdata,
   output cpu_pkg::mem_req_t      mem_req,
   output logic [3:0]             ra_idx,
   output logic [3:0]             rb_idx,
   output logic                   wr_en,
   output logic [3:0]             wr_idx,
   output cpu_pkg::word_t         wr_data,
   output logic                   pc_inc,
   input  wire cpu_pkg::word_t    ra_data,
   input  wire cpu_pkg::word_t    rb_data,
   input  wire cpu_pkg::word_t    pc,
   output cpu_pkg::alu_op_e       alu_op,
   output cpu_pkg::word_t         alu_a,
   output cpu_pkg::word_t         alu_b,
   output cpu_pkg::flags_t        alu_fi,
   input  wire cpu_pkg::word_t    alu_res,
   input  wire cpu_pkg::flags_t   alu_fo,
   input  wire                    alu_wb_en,
   input  wire                    alu_flag_en
);

   logic [31:0]      ir;      // instruction register
   cpu_pkg::flags_t  flags;
   cpu_pkg::word_t   ld_q;    // word read by a load
   cpu_pkg::word_t   ea_q;    // address held from phase e into phase m
   cpu_pkg::decode_t dec;
   logic             is_alu;
   logic             cond_ok;
   cpu_pkg::word_t   imm_sx;
   cpu_pkg::word_t   ea;
   cpu_pkg::word_t   call_target;

   function automatic logic cond_pass(input cpu_pkg::cond_e cond, input cpu_pkg::flags_t f);
      case (cond)
         cpu_pkg::cond_al: cond_pass = 1'b1;
         cpu_pkg::cond_eq: cond_pass = f.z;
         cpu_pkg::cond_ne: cond_pass = !f.z;
         cpu_pkg::cond_cs: cond_pass = f.c;
         cpu_pkg::cond_cc: cond_pass = !f.c;
         cpu_pkg::cond_mi: cond_pass = f.s;
         cpu_pkg::cond_pl: cond_pass = !f.s;
         cpu_pkg::cond_vs: cond_pass = f.v;
         cpu_pkg::cond_vc: cond_pass = !f.v;
         default:          cond_pass = 1'b0;   // nv and unused codes
      endcase
   endfunction

   always_comb
   begin
      dec.cls     = cpu_pkg::inst_class_e'(ir[27:25]);
      dec.cond    = cpu_pkg::cond_e'(ir[31:28]);
      dec.rd      = ir[23:20];
      dec.op      = cpu_pkg::alu_op_e'(ir[19:16]);
      dec.ra      = ir[15:12];
      dec.rb      = ir[11:8];
      dec.imm     = ir[15:0];
      dec.ld      = (dec.cls == cpu_pkg::cls_ld_r) || (dec.cls == cpu_pkg::cls_ld_i);
      dec.st      = (dec.cls == cpu_pkg::cls_st_r) || (dec.cls == cpu_pkg::cls_st_i);
      dec.call    = (dec.cls == cpu_pkg::cls_call);
      is_alu      = (dec.cls == cpu_pkg::cls_alu_r) || (dec.cls == cpu_pkg::cls_alu_i);
      dec.flag_wb = is_alu;   // alu op decides at writeback
      dec.wb      = is_alu || dec.ld || dec.call;
   end

   assign cond_ok = cond_pass(dec.cond, flags);
   assign imm_sx  = {{16{dec.imm[15]}}, dec.imm};

   // immediate alu form works on rd, call reads rd as its base
   assign ra_idx = ((dec.cls == cpu_pkg::cls_alu_i) || dec.call) ? dec.rd : dec.ra;
   assign rb_idx = (dec.st && phase.m) ? dec.rd : dec.rb;   // store data in phase m

   assign ea = ra_data + (ir[26] ? imm_sx : rb_data);   // ir[26] set for imm offset

   assign call_target = ir[24] ? ra_data + {{12{ir[19]}}, ir[19:0]}
                               : {8'h00, ir[23:0]};

   assign alu_op = dec.op;
   assign alu_a  = ra_data;
   assign alu_b  = (dec.cls == cpu_pkg::cls_alu_i) ? imm_sx : rb_data;
   assign alu_fi = flags;

   assign mem_req.addr  = (phase.m && (dec.ld || dec.st)) ? ea_q : pc;
   assign mem_req.wdata = rb_data;
   assign mem_req.wen   = phase.m && dec.st && cond_ok;

   assign pc_inc  = phase.e;
   // cmp and tst leave rd alone
   assign wr_en   = phase.w && cond_ok && dec.wb && (alu_wb_en || !is_alu);
   assign wr_idx  = dec.call ? cpu_pkg::pc_reg : dec.rd;   // call is a jump
   assign wr_data = dec.call ? call_target :
                    dec.ld   ? ld_q        :
                               alu_res;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ir    <= '0;
         flags <= '0;
      end
      else
      begin
         if (phase.f)
            ir <= mem_rdata;
         if (phase.w && cond_ok && dec.flag_wb && alu_flag_en)
            flags <= alu_fo;
      end
   end

   always_ff @(posedge clk)
   begin
      if (phase.e)
         ea_q <= ea;
      if (phase.m && dec.ld)
         ld_q <= mem_rdata;
   end

   // stores only in the memory slot of the scheduler ring
   a_wen_phase_m : assert property (@(posedge clk) disable iff (reset)
      mem_req.wen |-> phase.m && $past(phase.e));

endmodule

`default_nettype wire

// ==== hdl/code_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module code_mem #(
   parameter int mem_depth = 256
) (
   input  wire                     clk,
   input  wire cpu_pkg::mem_req_t  req,
   output cpu_pkg::word_t          rdata,
   input  wire                     load_en,
   input  wire cpu_pkg::word_t     load_addr,
   input  wire cpu_pkg::word_t     load_data
);

   localparam int aw = (mem_depth > 1) ? $clog2(mem_depth) : 1;

   cpu_pkg::word_t mem [mem_depth];
   logic [aw-1:0]  req_idx;
   logic [aw-1:0]  load_idx;

   // word addresses wrap around the array
   assign req_idx  = aw'(req.addr % 32'(mem_depth));
   assign load_idx = aw'(load_addr % 32'(mem_depth));

   always_ff @(posedge clk)
   begin
      if (load_en)
         mem[load_idx] <= load_data;   // preload during reset
      else if (req.wen)
         mem[req_idx] <= req.wdata;
   end

   assign rdata = mem[req_idx];   // answers in the same cycle

endmodule

`default_nettype wire

// ==== hdl/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
   parameter int mem_depth = 256
) (
   input  wire                  clk,
   input  wire                  reset,
   input  wire                  load_en,
   input  wire cpu_pkg::word_t  load_addr,
   input  wire cpu_pkg::word_t  load_data,
   input  wire [3:0]            test_rsel,
   output cpu_pkg::word_t       test_reg,
   output cpu_pkg::phase_t      phase,
   output cpu_pkg::mem_req_t    mem_req
);

   cpu_pkg::word_t   mem_rdata;
   logic [3:0]       ra_idx;
   logic [3:0]       rb_idx;
   logic             wr_en;
   logic [3:0]       wr_idx;
   cpu_pkg::word_t   wr_data;
   logic             pc_inc;
   cpu_pkg::word_t   ra_data;
   cpu_pkg::word_t   rb_data;
   cpu_pkg::word_t   pc;
   cpu_pkg::alu_op_e alu_op;
   cpu_pkg::word_t   alu_a;
   cpu_pkg::word_t   alu_b;
   cpu_pkg::flags_t  alu_fi;
   cpu_pkg::word_t   alu_res;
   cpu_pkg::flags_t  alu_fo;
   logic             alu_wb_en;
   logic             alu_flag_en;

   phase_sched phase_sched_i (
      .clk   (clk),
      .reset (reset),
      .phase (phase)
   );

   cpu_core cpu_core_i (
      .clk         (clk),
      .reset       (reset),
      .phase       (phase),
      .mem_rdata   (mem_rdata),
      .mem_req     (mem_req),
      .ra_idx      (ra_idx),
      .rb_idx      (rb_idx),
      .wr_en       (wr_en),
      .wr_idx      (wr_idx),
      .wr_data     (wr_data),
      .pc_inc      (pc_inc),
      .ra_data     (ra_data),
      .rb_data     (rb_data),
      .pc          (pc),
      .alu_op      (alu_op),
      .alu_a       (alu_a),
      .alu_b       (alu_b),
      .alu_fi      (alu_fi),
      .alu_res     (alu_res),
      .alu_fo      (alu_fo),
      .alu_wb_en   (alu_wb_en),
      .alu_flag_en (alu_flag_en)
   );

   reg_bank reg_bank_i (
      .clk       (clk),
      .reset     (reset),
      .ra_idx    (ra_idx),
      .rb_idx    (rb_idx),
      .wr_idx    (wr_idx),
      .wr_en     (wr_en),
      .wr_data   (wr_data),
      .pc_inc    (pc_inc),
      .ra_data   (ra_data),
      .rb_data   (rb_data),
      .pc        (pc),
      .test_rsel (test_rsel),
      .test_reg  (test_reg)
   );

   alu alu_i (
      .op      (alu_op),
      .a       (alu_a),
      .b       (alu_b),
      .fi      (alu_fi),
      .res     (alu_res),
      .fo      (alu_fo),
      .wb_en   (alu_wb_en),
      .flag_en (alu_flag_en)
   );

   code_mem #(
      .mem_depth (mem_depth)
   ) code_mem_i (
      .clk       (clk),
      .req       (mem_req),
      .rdata     (mem_rdata),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data)
   );

endmodule

`default_nettype wire

// ==== tests/cpu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
   input  wire                     clk,
   input  wire                     reset,
   input  wire cpu_pkg::phase_t    phase,
   input  wire cpu_pkg::mem_req_t  mem_req,
   input  wire [3:0]               test_rsel,
   input  wire cpu_pkg::word_t     test_reg,
   input  wire                     sample,
   input  wire                     done,
   input  logic [31:0]             stim [128],
   output int                      errors,
   output int                      tests
);

   cpu_pkg::phase_t exp_phase;
   int              phase_cnt;
   int              n_store;
   int              phase_err;
   int              store_err;

   initial
   begin
      errors    = 0;
      tests     = 0;
      phase_cnt = 0;
      n_store   = 0;
      phase_err = 0;
      store_err = 0;
   end

   always @(posedge clk)
   begin
      if (!reset)
      begin
         // token starts at f and moves one place per cycle
         exp_phase = cpu_pkg::phase_t'(4'b1000 >> (phase_cnt % 4));
         if (phase !== exp_phase)
         begin
            $display("FAILED %0t phase expected %b got %b", $time, exp_phase, phase);
            phase_err++;
         end
         phase_cnt++;
         if (mem_req.wen)
         begin
            if (!phase.m)
            begin
               $display("store strobe seen outside phase m at %0t", $time);
               store_err++;
            end
            if (n_store >= stim[2])
            begin
               $display("more stores than expected at %0t", $time);
               store_err++;
            end
            else
            begin
               if (mem_req.addr !== stim[80 + 2 * n_store])
               begin
                  $display("FAILED %0t mem_req.addr expected %h got %h", $time,
                     stim[80 + 2 * n_store], mem_req.addr);
                  store_err++;
               end
               if (mem_req.wdata !== stim[81 + 2 * n_store])
               begin
                  $display("FAILED %0t mem_req.wdata expected %h got %h", $time,
                     stim[81 + 2 * n_store], mem_req.wdata);
                  store_err++;
               end
            end
            n_store++;
         end
      end
   end

   always @(posedge sample)
   begin
      tests++;
      if (test_reg !== stim[64 + test_rsel])
      begin
         $display("FAILED %0t test_reg r%0d expected %h got %h", $time, test_rsel,
            stim[64 + test_rsel], test_reg);
         errors++;
      end
      else
         $display("register r%0d readback ok", test_rsel);
   end

   always @(posedge done)
   begin
      tests += 2;
      if (n_store != stim[2])
      begin
         $display("store count wrong, expected %0d but saw %0d", stim[2], n_store);
         store_err++;
      end
      $display("phase sequence: %0d errors", phase_err);
      $display("store trace: %0d errors", store_err);
      errors += phase_err + store_err;
   end

endmodule

`default_nettype wire

// ==== tests/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

   localparam int mem_depth = 256;

   logic                clk;
   logic                reset;
   logic                load_en;
   cpu_pkg::word_t      load_addr;
   cpu_pkg::word_t      load_data;
   logic [3:0]          test_rsel;
   cpu_pkg::word_t      test_reg;
   cpu_pkg::phase_t     phase;
   cpu_pkg::mem_req_t   mem_req;
   logic                sample;
   logic                done;
   logic [31:0]         stim [128];   // header, program, expected regs, expected stores
   int                  prog_len;
   int                  n_inst;
   int                  cycles = 0;
   int                  cycle_limit = 1000;
   int                  errors;
   int                  tests;

   cpu_top #(
      .mem_depth (mem_depth)
   ) cpu_top_i (
      .clk       (clk),
      .reset     (reset),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data),
      .test_rsel (test_rsel),
      .test_reg  (test_reg),
      .phase     (phase),
      .mem_req   (mem_req)
   );

   cpu_checker cpu_checker (
      .clk       (clk),
      .reset     (reset),
      .phase     (phase),
      .mem_req   (mem_req),
      .test_rsel (test_rsel),
      .test_reg  (test_reg),
      .sample    (sample),
      .done      (done),
      .stim      (stim),
      .errors    (errors),
      .tests     (tests)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // limit covers preload, reset, the program and some slack
   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles > cycle_limit)
      begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("test failed");
         $finish;
      end
   end

   initial
   begin
      reset     = 1'b1;
      load_en   = 1'b0;
      load_addr = '0;
      load_data = '0;
      test_rsel = '0;
      sample    = 1'b0;
      done      = 1'b0;
      $readmemh("tests/cpu_stim.txt", stim);
      prog_len    = stim[0];
      n_inst      = stim[1];
      cycle_limit = prog_len + 3 + 4 * n_inst + 64;

      for (int i = 0; i < prog_len; i++)
      begin
         @(negedge clk);
         load_en   = 1'b1;
         load_addr = i;
         load_data = stim[16 + i];
      end
      @(negedge clk);
      load_en = 1'b0;
      repeat (2) @(negedge clk);
      reset = 1'b0;

      repeat (4 * n_inst) @(posedge clk);   // four phases per instruction
      @(negedge clk);

      // sweep within half a cycle, before the next pc update
      for (int i = 0; i < 16; i++)
      begin
         test_rsel = 4'(i);
         #0.5 sample = 1'b1;
         #0.5 sample = 1'b0;
      end
      done = 1'b1;
      #1;
      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tests/cpu_stim.txt ====
// @00 program length, instructions executed, store count
// @10 program words, @40 expected r0..r15, @50 expected stores as address data
@00
0000001A 00000016 00000002
@10
02170005 // mov r1, #5
02270123 // mov r2, #0x123
00301200 // add r3, r1, r2
00412100 // sub r4, r2, r1
00543400 // xor r5, r3, r4
02150004 // shl r1, #4
00631500 // or r6, r1, r5
0277FFF0 // mov r7, #-16
02760008 // shr r7, #8
00827200 // and r8, r7, r2
00088200 // cmp r8, r2
22A70022 // ne mov r10, skipped
12970011 // eq mov r9
0C600080 // st r6, [r0 + 0x80]
08301500 // st r3, [r1 + r5]
0EB00080 // ld r11, [r0 + 0x80]
0AC01500 // ld r12, [r1 + r5]
04000014 // call 20
02D70099 // skipped
02D70098 // skipped
02D70033 // mov r13, #0x33
051FFFC8 // call r1 - 56
02E70077 // skipped
02D70055 // skipped
02E00007 // add r14, #7
06000000 // nop, last
@40
00000000 00000050 00000123 00000128
0000011E 00000036 00000076 00FFFFFF
00000123 00000011 00000000 00000076
00000128 00000033 00000007 0000001A
@50
00000080 00000076
00000086 00000128

// ==== src.f ====
hdl/cpu_pkg.sv
hdl/phase_sched.sv
hdl/reg_bank.sv
hdl/alu.sv
hdl/cpu_core.sv
hdl/code_mem.sv
hdl/cpu_top.sv
tests/cpu_checker.sv
tests/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -f src.f --top-module cpu_tb -o cpu_sim \
   && ./obj_dir/cpu_sim | grep "test passed" \
   || { echo "simulation did not pass"; exit 1; }
